/* src.f */
+incdir+hw
hw/cdc_link_pkg.sv
hw/gray_addr_counter.sv
hw/ram_t2p_asym.sv
hw/fifo_async_asym.sv
hw/word_source.sv
hw/byte_checker.sv
hw/cdc_link_top.sv
tests/tb_cdc_link.sv

/* tests/tb_cdc_link.sv */
`include "cdc_link_macros.svh"

module tb_cdc_link
   import cdc_link_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // longest possible run: 5 + 12 + 8 random bursts of up to 15 + break burst of 6
   localparam int MAX_WORDS  = 5 + 12 + 8 * 15 + 6;
   localparam real W_PERIOD  = 7.0;
   localparam real TIMEOUT_NS = MAX_WORDS * 20 * W_PERIOD + 2000.0;

   localparam fifo_flags_t IDLE_FLAGS = '{empty: 1'b1, full: 1'b0, level: '0};
   localparam fifo_flags_t FULL_FLAGS = '{empty: 1'b0, full: 1'b1, level: `CDC_FIFO_SIZE};

   logic        w_clk;
   logic        r_clk;
   logic        rst_n;
   logic        start;
   burst_cmd_t  cmd;
   logic        rd_enable;
   logic        busy;
   fifo_flags_t w_flags;
   fifo_flags_t r_flags;
   rx_status_t  status;

   // reference model of what the checker should report
   rx_status_t  exp_status;
   logic        have_first;

   logic        chk_reset;
   logic        chk_status;
   logic        chk_full;
   logic        bursts_done;
   integer      seed;
   int          err_count;
   int          pass_count;
   int          fail_count;

   cdc_link_top dut0 (
      .w_clk     (w_clk),
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .start     (start),
      .cmd       (cmd),
      .rd_enable (rd_enable),
      .busy      (busy),
      .w_flags   (w_flags),
      .r_flags   (r_flags),
      .status    (status)
   );

   initial begin
      r_clk = 1'b0;
      forever #2 r_clk = ~r_clk;
   end

   // unrelated to r_clk on purpose
   initial begin
      w_clk = 1'b0;
      forever #(W_PERIOD / 2.0) w_clk = ~w_clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("TIMEOUT: the run did not complete within %0.0f ns", TIMEOUT_NS);
      $display("=== FAIL ===");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR %0t ns: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      err_count++;
   endtask

   a_reset_r_flags : assert property (@(posedge r_clk) chk_reset |-> r_flags == IDLE_FLAGS)
      else report_mismatch("r_flags", IDLE_FLAGS, $sampled(r_flags));
   a_reset_status : assert property (@(posedge r_clk) chk_reset |-> status == '0)
      else report_mismatch("status", 32'd0, $sampled(status));
   a_reset_w_flags : assert property (@(posedge w_clk) chk_reset |-> w_flags == IDLE_FLAGS)
      else report_mismatch("w_flags", IDLE_FLAGS, $sampled(w_flags));
   a_reset_busy : assert property (@(posedge w_clk) chk_reset |-> !busy)
      else report_mismatch("busy", 32'd0, $sampled(busy));

   a_byte_count : assert property (
      @(posedge r_clk) chk_status |-> status.byte_count == exp_status.byte_count)
      else report_mismatch("status.byte_count", exp_status.byte_count,
                           $sampled(status.byte_count));
   a_error_count : assert property (
      @(posedge r_clk) chk_status |-> status.error_count == exp_status.error_count)
      else report_mismatch("status.error_count", exp_status.error_count,
                           $sampled(status.error_count));
   a_last_byte : assert property (
      @(posedge r_clk) chk_status |-> status.last_byte == exp_status.last_byte)
      else report_mismatch("status.last_byte", exp_status.last_byte,
                           $sampled(status.last_byte));
   a_idle_after : assert property (@(posedge w_clk) chk_status |-> !busy)
      else report_mismatch("busy", 32'd0, $sampled(busy));

   a_full_flags : assert property (@(posedge w_clk) chk_full |-> w_flags == FULL_FLAGS)
      else report_mismatch("w_flags", FULL_FLAGS, $sampled(w_flags));
   a_full_busy : assert property (@(posedge w_clk) chk_full |-> busy)
      else report_mismatch("busy", 32'd1, $sampled(busy));

   // the fill level may never exceed the storage in either domain
   a_w_level_max : assert property (
      @(posedge w_clk) disable iff (!rst_n) w_flags.level <= `CDC_FIFO_SIZE)
      else report_mismatch("w_flags.level", `CDC_FIFO_SIZE, $sampled(w_flags.level));
   a_r_level_max : assert property (
      @(posedge r_clk) disable iff (!rst_n) r_flags.level <= `CDC_FIFO_SIZE)
      else report_mismatch("r_flags.level", `CDC_FIFO_SIZE, $sampled(r_flags.level));

   // source and checker must respect the FIFO flags
   a_no_write_full : assert property (
      @(posedge w_clk) disable iff (!rst_n) dut0.wr_en |-> !w_flags.full)
      else report_mismatch("dut0.wr_en", 32'd0, $sampled(dut0.wr_en));
   a_no_read_empty : assert property (
      @(posedge r_clk) disable iff (!rst_n) dut0.rd_en |-> !r_flags.empty)
      else report_mismatch("dut0.rd_en", 32'd0, $sampled(dut0.rd_en));

   // issues one burst and updates the reference sequence
   task automatic send_burst(input logic [7:0] sb, input logic [3:0] n);
      while (busy) begin
         @(posedge w_clk);
         #1;
      end
      if (have_first && sb != exp_status.last_byte + 8'd1 && exp_status.error_count != 8'hff) begin
         exp_status.error_count = exp_status.error_count + 8'd1;
      end
      have_first = 1'b1;
      exp_status.byte_count = exp_status.byte_count + 16'(4 * n);
      exp_status.last_byte  = sb + 8'(4 * n - 1);
      @(posedge w_clk);
      #1;
      start = 1'b1;
      cmd   = '{start_byte: sb, word_count: n};
      @(posedge w_clk);
      #1;
      start = 1'b0;
   endtask

   task automatic wait_for_bytes();
      @(posedge r_clk);
      #1;
      while (status.byte_count < exp_status.byte_count) begin
         @(posedge r_clk);
         #1;
      end
   endtask

   // window long enough to cover two w_clk edges
   task automatic check_status();
      @(posedge r_clk);
      #1;
      chk_status = 1'b1;
      repeat (4) @(posedge r_clk);
      #1;
      chk_status = 1'b0;
      @(posedge r_clk);
   endtask

   task automatic close_test(input int num, input string name, input int errs_before);
      if (err_count == errs_before) begin
         pass_count++;
         $display("test %0d %s: passed", num, name);
      end else begin
         fail_count++;
         $display("test %0d %s: failed with %0d errors", num, name, err_count - errs_before);
      end
   endtask

   initial begin
      int          errs_before;
      int unsigned rnd;
      rst_n       = 1'b0;
      start       = 1'b0;
      cmd         = '0;
      rd_enable   = 1'b0;
      chk_reset   = 1'b0;
      chk_status  = 1'b0;
      chk_full    = 1'b0;
      bursts_done = 1'b0;
      exp_status  = '0;
      have_first  = 1'b0;
      seed        = 8098;
      err_count   = 0;
      pass_count  = 0;
      fail_count  = 0;
      repeat (10) @(posedge r_clk);
      #1;
      rst_n = 1'b1;

      errs_before = err_count;
      repeat (2) @(posedge w_clk);
      #1;
      chk_reset = 1'b1;
      repeat (3) @(posedge w_clk);
      #1;
      chk_reset = 1'b0;
      @(posedge w_clk);
      close_test(1, "reset_state", errs_before);

      errs_before = err_count;
      @(posedge r_clk);
      #1;
      rd_enable = 1'b1;
      send_burst(8'h10, 4'd5);
      wait_for_bytes();
      check_status();
      close_test(2, "single_burst", errs_before);

      // reads held off so the FIFO fills and the source stalls
      errs_before = err_count;
      @(posedge r_clk);
      #1;
      rd_enable = 1'b0;
      send_burst(exp_status.last_byte + 8'd1, 4'd12);
      for (int i = 0; i < 200 && !w_flags.full; i++) begin
         @(posedge w_clk);
         #1;
      end
      repeat (2) @(posedge w_clk);
      #1;
      chk_full = 1'b1;
      repeat (3) @(posedge w_clk);
      #1;
      chk_full = 1'b0;
      @(posedge r_clk);
      #1;
      rd_enable = 1'b1;
      wait_for_bytes();
      check_status();
      close_test(3, "back_pressure", errs_before);

      errs_before = err_count;
      fork
         begin
            for (int i = 0; i < 8; i++) begin
               rnd = $random(seed);
               send_burst(exp_status.last_byte + 8'd1, 4'((rnd % 15) + 1));
            end
            bursts_done = 1'b1;
         end
         begin
            while (!bursts_done) begin
               @(posedge r_clk);
               #1;
               rd_enable = $random(seed) & 1;
            end
         end
      join
      @(posedge r_clk);
      #1;
      rd_enable = 1'b1;
      wait_for_bytes();
      check_status();
      close_test(4, "random_bursts", errs_before);

      // start byte jumps ahead of the running sequence
      errs_before = err_count;
      send_burst(exp_status.last_byte + 8'h41, 4'd6);
      wait_for_bytes();
      check_status();
      close_test(5, "sequence_break", errs_before);

      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* hw/cdc_link_top.sv */
`include "cdc_link_macros.svh"

module cdc_link_top
   import cdc_link_pkg::*;
(
   input  logic        w_clk,
   input  logic        r_clk,
   input  logic        rst_n,
   input  logic        start,
   input  burst_cmd_t  cmd,
   input  logic        rd_enable,
   output logic        busy,
   output fifo_flags_t w_flags,
   output fifo_flags_t r_flags,
   output rx_status_t  status
);

   logic                     wr_en;
   logic [`CDC_W_DATA_W-1:0] wr_data;
   logic                     rd_en;
   logic [`CDC_R_DATA_W-1:0] rd_data;

   // write domain producer
   word_source src0 (
      .w_clk   (w_clk),
      .rst_n   (rst_n),
      .start   (start),
      .cmd     (cmd),
      .full    (w_flags.full),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .busy    (busy)
   );

   fifo_async_asym fifo0 (
      .w_clk   (w_clk),
      .r_clk   (r_clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .w_flags (w_flags),
      .r_flags (r_flags)
   );

   // read domain consumer
   byte_checker chk0 (
      .r_clk     (r_clk),
      .rst_n     (rst_n),
      .rd_enable (rd_enable),
      .empty     (r_flags.empty),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .status    (status)
   );

endmodule

/* hw/byte_checker.sv */
`include "cdc_link_macros.svh"

module byte_checker
   import cdc_link_pkg::*;
(
   input  logic                     r_clk,
   input  logic                     rst_n,
   input  logic                     rd_enable,
   input  logic                     empty,
   output logic                     rd_en,
   input  logic [`CDC_R_DATA_W-1:0] rd_data,
   output rx_status_t               status
);

   logic                     rd_valid;
   logic                     have_first;
   logic [`CDC_R_DATA_W-1:0] expect_byte;

   assign rd_en       = rd_enable & ~empty;
   assign expect_byte = status.last_byte + `CDC_R_DATA_W'(1);

   // strobe delayed to line up with the registered RAM output
   always_ff @(posedge r_clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;
      end
   end

   always_ff @(posedge r_clk) begin
      if (!rst_n) begin
         have_first <= 1'b0;
         status     <= '0;
      end else if (rd_valid) begin
         have_first        <= 1'b1;
         status.byte_count <= status.byte_count + 16'd1;
         status.last_byte  <= rd_data;
         // resync to whatever arrived, so one break counts once
         if (have_first && rd_data != expect_byte && status.error_count != 8'hff) begin
            status.error_count <= status.error_count + 8'd1;
         end
      end
   end

endmodule

/* hw/word_source.sv */
`include "cdc_link_macros.svh"

module word_source
   import cdc_link_pkg::*;
(
   input  logic                     w_clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  burst_cmd_t               cmd,
   input  logic                     full,
   output logic                     wr_en,
   output logic [`CDC_W_DATA_W-1:0] wr_data,
   output logic                     busy
);

   src_state_e               state;
   logic [3:0]               words_left;
   logic [`CDC_R_DATA_W-1:0] next_byte;

   assign busy  = (state != SRC_IDLE);
   assign wr_en = busy & ~full;

   // lowest byte of the run goes in lane 0
   always_comb begin
      for (int i = 0; i < `CDC_LANES; i++) begin
         wr_data[i*`CDC_R_DATA_W +: `CDC_R_DATA_W] = next_byte + `CDC_R_DATA_W'(i);
      end
   end

   always_ff @(posedge w_clk) begin
      if (!rst_n) begin
         state      <= SRC_IDLE;
         words_left <= '0;
      end else begin
         case (state)
            SRC_IDLE: begin
               if (start && cmd.word_count != 0) begin
                  state      <= SRC_SEND;
                  words_left <= cmd.word_count;
               end
            end
            SRC_SEND, SRC_STALL: begin
               if (full) begin
                  state <= SRC_STALL;
               end else begin
                  words_left <= words_left - 4'd1;
                  state      <= (words_left == 4'd1) ? SRC_IDLE : SRC_SEND;
               end
            end
            default: state <= SRC_IDLE;
         endcase
      end
   end

   always_ff @(posedge w_clk) begin
      if (state == SRC_IDLE && start) begin
         next_byte <= cmd.start_byte;
      end else if (wr_en) begin
         next_byte <= next_byte + `CDC_R_DATA_W'(`CDC_LANES);
      end
   end

endmodule

/* hw/fifo_async_asym.sv */
`include "cdc_link_macros.svh"

module fifo_async_asym
   import cdc_link_pkg::*;
(
   input  logic                     w_clk,
   input  logic                     r_clk,
   input  logic                     rst_n,

   input  logic                     wr_en,
   input  logic [`CDC_W_DATA_W-1:0] wr_data,
   input  logic                     rd_en,
   output logic [`CDC_R_DATA_W-1:0] rd_data,

   output fifo_flags_t              w_flags,
   output fifo_flags_t              r_flags
);

   // write pointer counts words, read pointer counts bytes, both with a wrap bit
   logic [`CDC_W_ADDR_W:0] w_gray;
   logic [`CDC_W_ADDR_W:0] w_bin;
   logic [`CDC_W_ADDR_W:0] w_bin_nxt;
   logic [`CDC_ADDR_W:0]   r_gray;
   logic [`CDC_ADDR_W:0]   r_bin;
   logic [`CDC_ADDR_W:0]   r_bin_nxt;

   logic [`CDC_ADDR_W:0]   w_r_sync [`CDC_SYNC_STAGES];
   logic [`CDC_W_ADDR_W:0] r_w_sync [`CDC_SYNC_STAGES];
   logic [`CDC_ADDR_W:0]   w_r_bin;
   logic [`CDC_ADDR_W:0]   r_w_bin;

   logic                   wr_ok;
   logic                   rd_ok;
   logic [`CDC_ADDR_W:0]   w_level_nxt;
   logic [`CDC_ADDR_W:0]   r_level_nxt;
   logic [`CDC_ADDR_W:0]   w_level;
   logic [`CDC_ADDR_W:0]   r_level;
   fill_state_e            w_state;
   fill_state_e            r_state;

   // above size minus one write is full, below one read is empty
   function automatic fill_state_e fill_next(
      input fill_state_e          cur,
      input logic [`CDC_ADDR_W:0] lvl_old,
      input logic [`CDC_ADDR_W:0] lvl_new
   );
      fill_state_e nxt;
      nxt = cur;
      if (lvl_new > `CDC_FIFO_SIZE - `CDC_LANES) begin
         nxt = FILL_FULL;
      end else if (lvl_new < 1) begin
         nxt = FILL_EMPTY;
      end else if (lvl_new > lvl_old) begin
         nxt = FILL_RISING;
      end else if (lvl_new < lvl_old) begin
         nxt = FILL_FALLING;
      end
      return nxt;
   endfunction

   // attempts while full or empty are dropped
   assign wr_ok = wr_en & ~w_flags.full;
   assign rd_ok = rd_en & ~r_flags.empty;

   gray_addr_counter #(
      .W(`CDC_W_ADDR_W + 1)
   ) w_cnt0 (
      .r_clk (w_clk),
      .rst_n (rst_n),
      .en    (wr_ok),
      .gray  (w_gray),
      .bin   (w_bin)
   );

   gray_addr_counter #(
      .W(`CDC_ADDR_W + 1)
   ) r_cnt0 (
      .r_clk (r_clk),
      .rst_n (rst_n),
      .en    (rd_ok),
      .gray  (r_gray),
      .bin   (r_bin)
   );

   ram_t2p_asym ram0 (
      .w_clk   (w_clk),
      .wr_en   (wr_ok),
      .wr_addr (w_bin[`CDC_W_ADDR_W-1:0]),
      .wr_data (wr_data),
      .r_clk   (r_clk),
      .rd_en   (rd_ok),
      .rd_addr (r_bin[`CDC_ADDR_W-1:0]),
      .rd_data (rd_data)
   );

   // read pointer into the write domain
   always_ff @(posedge w_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
            w_r_sync[i] <= '0;
         end
      end else begin
         w_r_sync[0] <= r_gray;
         for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
            w_r_sync[i] <= w_r_sync[i - 1];
         end
      end
   end

   // write pointer into the read domain
   always_ff @(posedge r_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
            r_w_sync[i] <= '0;
         end
      end else begin
         r_w_sync[0] <= w_gray;
         for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
            r_w_sync[i] <= r_w_sync[i - 1];
         end
      end
   end

   assign w_r_bin = gray_to_bin(w_r_sync[`CDC_SYNC_STAGES-1]);
   assign r_w_bin = gray_to_bin((`CDC_ADDR_W + 1)'(r_w_sync[`CDC_SYNC_STAGES-1]));

   // levels include the access of this cycle, word pointers scaled to bytes
   assign w_bin_nxt   = w_bin + {{`CDC_W_ADDR_W{1'b0}}, wr_ok};
   assign r_bin_nxt   = r_bin + {{`CDC_ADDR_W{1'b0}}, rd_ok};
   assign w_level_nxt = {w_bin_nxt, {`CDC_LANE_SEL_W{1'b0}}} - w_r_bin;
   assign r_level_nxt = {r_w_bin[`CDC_W_ADDR_W:0], {`CDC_LANE_SEL_W{1'b0}}} - r_bin_nxt;

   always_ff @(posedge w_clk) begin
      if (!rst_n) begin
         w_state <= FILL_EMPTY;
         w_level <= '0;
      end else begin
         w_state <= fill_next(w_state, w_level, w_level_nxt);
         w_level <= w_level_nxt;
      end
   end

   always_ff @(posedge r_clk) begin
      if (!rst_n) begin
         r_state <= FILL_EMPTY;
         r_level <= '0;
      end else begin
         r_state <= fill_next(r_state, r_level, r_level_nxt);
         r_level <= r_level_nxt;
      end
   end

   always_comb begin
      w_flags.empty = (w_state == FILL_EMPTY);
      w_flags.full  = (w_state == FILL_FULL);
      w_flags.level = w_level;
      r_flags.empty = (r_state == FILL_EMPTY);
      r_flags.full  = (r_state == FILL_FULL);
      r_flags.level = r_level;
   end

   a_no_write_full : assert property (
      @(posedge w_clk) disable iff (!rst_n) wr_en |-> !w_flags.full
   );

   a_no_read_empty : assert property (
      @(posedge r_clk) disable iff (!rst_n) rd_en |-> !r_flags.empty
   );

   // pointer arithmetic must never report more than the storage holds
   a_w_level_max : assert property (
      @(posedge w_clk) disable iff (!rst_n) w_flags.level <= `CDC_FIFO_SIZE
   );

   a_r_level_max : assert property (
      @(posedge r_clk) disable iff (!rst_n) r_flags.level <= `CDC_FIFO_SIZE
   );

endmodule

/* hw/ram_t2p_asym.sv */
`include "cdc_link_macros.svh"

module ram_t2p_asym (
   // write port, one full word per write
   input  logic                      w_clk,
   input  logic                      wr_en,
   input  logic [`CDC_W_ADDR_W-1:0]  wr_addr,
   input  logic [`CDC_W_DATA_W-1:0]  wr_data,

   // read port, one byte per read
   input  logic                      r_clk,
   input  logic                      rd_en,
   input  logic [`CDC_ADDR_W-1:0]    rd_addr,
   output logic [`CDC_R_DATA_W-1:0]  rd_data
);

   // lane 0 holds the least significant byte
   logic [`CDC_LANES-1:0][`CDC_R_DATA_W-1:0] mem [1 << `CDC_W_ADDR_W];

   logic [`CDC_W_ADDR_W-1:0]   rd_word;
   logic [`CDC_LANE_SEL_W-1:0] rd_lane;

   assign rd_word = rd_addr[`CDC_ADDR_W-1:`CDC_LANE_SEL_W];
   assign rd_lane = rd_addr[`CDC_LANE_SEL_W-1:0];

   always_ff @(posedge w_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered byte, valid one r_clk after rd_en
   always_ff @(posedge r_clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_word][rd_lane];
      end
   end

endmodule

/* hw/gray_addr_counter.sv */
`include "cdc_link_macros.svh"

module gray_addr_counter #(
   parameter int W = `CDC_ADDR_W + 1
) (
   input  logic         r_clk,
   input  logic         rst_n,
   input  logic         en,
   output logic [W-1:0] gray,
   output logic [W-1:0] bin
);

   logic [W-1:0] bin_nxt;

   assign bin_nxt = bin + W'(en);

   // gray taken from the next count so it leaves a flop cleanly
   always_ff @(posedge r_clk) begin
      if (!rst_n) begin
         bin  <= '0;
         gray <= '0;
      end else begin
         bin  <= bin_nxt;
         gray <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

endmodule

/* hw/cdc_link_pkg.sv */
`include "cdc_link_macros.svh"

package cdc_link_pkg;

   // last direction of change of the fill level
   typedef enum logic [1:0] {FILL_EMPTY, FILL_FALLING, FILL_RISING, FILL_FULL} fill_state_e;

   typedef enum logic [1:0] {SRC_IDLE, SRC_SEND, SRC_STALL} src_state_e;

   typedef struct packed {
      logic                 empty;
      logic                 full;
      logic [`CDC_ADDR_W:0] level;
   } fifo_flags_t;

   typedef struct packed {
      logic [`CDC_R_DATA_W-1:0] start_byte;
      logic [3:0]               word_count;
   } burst_cmd_t;

   typedef struct packed {
      logic [15:0]              byte_count;
      logic [7:0]               error_count;
      logic [`CDC_R_DATA_W-1:0] last_byte;
   } rx_status_t;

   // narrower pointers are passed zero extended
   function automatic logic [`CDC_ADDR_W:0] gray_to_bin(input logic [`CDC_ADDR_W:0] g);
      logic [`CDC_ADDR_W:0] b;
      b[`CDC_ADDR_W] = g[`CDC_ADDR_W];
      for (int i = `CDC_ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i + 1] ^ g[i];
      end
      return b;
   endfunction

endpackage

/* hw/cdc_link_macros.svh */
`ifndef CDC_LINK_MACROS_SVH
`define CDC_LINK_MACROS_SVH

// write side word and read side byte
`define CDC_W_DATA_W 32
`define CDC_R_DATA_W 8

// byte addressed storage, 32 bytes
`define CDC_ADDR_W 5
`define CDC_FIFO_SIZE (1 << `CDC_ADDR_W)

// bytes per word and the lane select bits
`define CDC_LANES 4
`define CDC_LANE_SEL_W 2
`define CDC_W_ADDR_W (`CDC_ADDR_W - `CDC_LANE_SEL_W)

`define CDC_SYNC_STAGES 2

`endif
